/* rtl/mlp_defines.svh */
`ifndef MLP_DEFINES_SVH
`define MLP_DEFINES_SVH

// Fixed-point format of every data word
`define MLP_WIDTH 16
`define MLP_NFRAC 8

// Network shape
`define MLP_N_IN  4
`define MLP_N_HID 8
`define MLP_N_OUT 3

// Wide enough for a full dot product without overflow
`define MLP_ACC_WIDTH 40

// Entries between the receiver and layer 1
`define MLP_QUEUE_DEPTH 2

`endif

/* rtl/mlp_pkg.sv */
`include "mlp_defines.svh"

package mlp_pkg;

    // Signed, MLP_NFRAC fraction bits, so 256 is 1.0
    typedef logic signed [`MLP_WIDTH-1:0] fixed_t;

    // Element 0 sits in the low bits of each vector
    typedef struct packed {
        fixed_t x3;
        fixed_t x2;
        fixed_t x1;
        fixed_t x0;
    } feature_vec_t;

    typedef struct packed {
        fixed_t h7;
        fixed_t h6;
        fixed_t h5;
        fixed_t h4;
        fixed_t h3;
        fixed_t h2;
        fixed_t h1;
        fixed_t h0;
    } hidden_vec_t;

    typedef struct packed {
        fixed_t z2;
        fixed_t z1;
        fixed_t z0;
    } logit_vec_t;

    typedef struct packed {
        logic [1:0] class_idx;
        fixed_t     logit;
    } class_result_t;

    // Indexed [neuron][input]
    localparam fixed_t layer1_weights [`MLP_N_HID][`MLP_N_IN] = '{
        '{ 128,  -64,   32,   96},
        '{ -96,  160,   64,  -32},
        '{  64,   64, -128,   48},
        '{ -32,  -48,   96,  128},
        '{ 200,  -16,  -80,   24},
        '{-128,   96,  112,  -64},
        '{  40,  180,  -24, -100},
        '{ -72,  -40,  144,   88}
    };

    localparam fixed_t layer1_bias [`MLP_N_HID] = '{32, 0, -16, 64, 0, 16, -32, 8};

    // Rows 0 and 1 differ only where the zero-input hidden value is zero
    localparam fixed_t layer2_weights [`MLP_N_OUT][`MLP_N_HID] = '{
        '{  96,  -48,   80,  -64,  112,   32,  -96,   48},
        '{  96,  120,  -56,  -64,  -40,   32,   72,   48},
        '{ -80,   64,   40,   56,  -32,  -48,   88, -120}
    };

    localparam fixed_t layer2_bias [`MLP_N_OUT] = '{16, 16, -24};

endpackage

/* rtl/sample_receiver.sv */
`timescale 1ns/10ps

module sample_receiver (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    output logic                  in_ack,
    input  mlp_pkg::feature_vec_t in_sample,
    output logic                  sample_valid,
    input  logic                  sample_ready,
    output mlp_pkg::feature_vec_t sample_data
);

    typedef enum logic {
        S_IDLE,
        S_ACK
    } state_t;

    state_t state;
    logic   can_capture;
    logic   capture;

    // Holding register is free, or is being emptied this cycle
    assign can_capture = !sample_valid || sample_ready;
    assign capture     = (state == S_IDLE) && in_req && can_capture;
    assign in_ack      = (state == S_ACK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (capture) begin
                        state <= S_ACK;
                    end
                end
                // Hold the ack until the requester lets go
                S_ACK: begin
                    if (!in_req) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else if (capture) begin
            sample_valid <= 1'b1;
        end else if (sample_ready) begin
            sample_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            sample_data <= in_sample;
        end
    end

endmodule

/* rtl/sample_queue.sv */
`timescale 1ns/10ps
`include "mlp_defines.svh"

module sample_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  mlp_pkg::feature_vec_t wr_data,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output mlp_pkg::feature_vec_t rd_data
);
    import mlp_pkg::*;

    localparam int DEPTH   = `MLP_QUEUE_DEPTH;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    feature_vec_t       mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_write;
    logic               do_read;

    assign wr_ready = (count != COUNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign do_write = wr_valid && wr_ready;
    assign do_read  = rd_valid && rd_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count alone
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* rtl/dense_layer.sv */
`timescale 1ns/10ps
`include "mlp_defines.svh"

module dense_layer #(
    parameter int              IN_SIZE  = 4,
    parameter int              OUT_SIZE = 8,
    parameter bit              USE_RELU = 1'b1,
    parameter mlp_pkg::fixed_t WEIGHTS [OUT_SIZE][IN_SIZE] = '{default: '0},
    parameter mlp_pkg::fixed_t BIAS [OUT_SIZE] = '{default: '0}
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [IN_SIZE*`MLP_WIDTH-1:0]  in_data,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [OUT_SIZE*`MLP_WIDTH-1:0] out_data
);
    import mlp_pkg::*;

    localparam int IN_IDX_W  = (IN_SIZE > 1) ? $clog2(IN_SIZE) : 1;
    localparam int OUT_IDX_W = (OUT_SIZE > 1) ? $clog2(OUT_SIZE) : 1;

    // Limits of fixed_t, widened to the accumulator
    localparam logic signed [`MLP_ACC_WIDTH-1:0] SAT_MAX = (2 ** (`MLP_WIDTH - 1)) - 1;
    localparam logic signed [`MLP_ACC_WIDTH-1:0] SAT_MIN = -(2 ** (`MLP_WIDTH - 1));

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAC,
        S_FINISH,
        S_DONE
    } state_t;

    state_t                            state;
    logic [IN_IDX_W-1:0]               in_idx;
    logic [OUT_IDX_W-1:0]              out_idx;
    logic [IN_SIZE*`MLP_WIDTH-1:0]     x_reg;
    logic [OUT_SIZE*`MLP_WIDTH-1:0]    result_reg;
    logic signed [`MLP_ACC_WIDTH-1:0]  acc;
    fixed_t                            x_cur;
    fixed_t                            w_cur;
    logic signed [2*`MLP_WIDTH-1:0]    product;
    logic signed [`MLP_ACC_WIDTH-1:0]  scaled;
    logic signed [`MLP_ACC_WIDTH-1:0]  biased;
    fixed_t                            neuron_out;

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_DONE);
    assign out_data  = result_reg;

    // One multiplier shared over all inputs and neurons
    assign x_cur   = x_reg[in_idx*`MLP_WIDTH +: `MLP_WIDTH];
    assign w_cur   = WEIGHTS[out_idx][in_idx];
    assign product = x_cur * w_cur;

    // Arithmetic shift floors toward minus infinity
    assign scaled = acc >>> `MLP_NFRAC;
    assign biased = scaled + BIAS[out_idx];

    always_comb begin
        if (biased > SAT_MAX) begin
            neuron_out = SAT_MAX[`MLP_WIDTH-1:0];
        end else if (biased < SAT_MIN) begin
            neuron_out = SAT_MIN[`MLP_WIDTH-1:0];
        end else begin
            neuron_out = biased[`MLP_WIDTH-1:0];
        end
        if (USE_RELU && (neuron_out < 0)) begin
            neuron_out = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= S_IDLE;
            in_idx  <= '0;
            out_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        state   <= S_MAC;
                        in_idx  <= '0;
                        out_idx <= '0;
                    end
                end
                S_MAC: begin
                    if (in_idx == IN_IDX_W'(IN_SIZE - 1)) begin
                        state  <= S_FINISH;
                        in_idx <= '0;
                    end else begin
                        in_idx <= in_idx + 1'b1;
                    end
                end
                S_FINISH: begin
                    if (out_idx == OUT_IDX_W'(OUT_SIZE - 1)) begin
                        state <= S_DONE;
                    end else begin
                        state   <= S_MAC;
                        out_idx <= out_idx + 1'b1;
                    end
                end
                // Result held until the next stage takes it
                S_DONE: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (in_valid) begin
                    x_reg <= in_data;
                    acc   <= '0;
                end
            end
            S_MAC: begin
                acc <= acc + product;
            end
            S_FINISH: begin
                result_reg[out_idx*`MLP_WIDTH +: `MLP_WIDTH] <= neuron_out;
                acc <= '0;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/argmax_sender.sv */
`timescale 1ns/10ps

module argmax_sender (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   logit_valid,
    output logic                   logit_ready,
    input  mlp_pkg::logit_vec_t    logits,
    output logic                   out_req,
    input  logic                   out_ack,
    output mlp_pkg::class_result_t out_result
);
    import mlp_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ARGMAX,
        S_REQ,
        S_ACK_LOW
    } state_t;

    state_t        state;
    logit_vec_t    logit_reg;
    class_result_t best;

    assign logit_ready = (state == S_IDLE);
    assign out_req     = (state == S_REQ);

    // Strict compare so a tie keeps the lower index
    always_comb begin
        best.class_idx = 2'd0;
        best.logit     = logit_reg.z0;
        if (logit_reg.z1 > best.logit) begin
            best.class_idx = 2'd1;
            best.logit     = logit_reg.z1;
        end
        if (logit_reg.z2 > best.logit) begin
            best.class_idx = 2'd2;
            best.logit     = logit_reg.z2;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (logit_valid) begin
                        state <= S_ARGMAX;
                    end
                end
                S_ARGMAX: begin
                    state <= S_REQ;
                end
                S_REQ: begin
                    if (out_ack) begin
                        state <= S_ACK_LOW;
                    end
                end
                // Request already dropped, wait for the ack to follow
                S_ACK_LOW: begin
                    if (!out_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && logit_valid) begin
            logit_reg <= logits;
        end
        if (state == S_ARGMAX) begin
            out_result <= best;
        end
    end

endmodule

/* rtl/mlp_classifier.sv */
`timescale 1ns/10ps
`include "mlp_defines.svh"

module mlp_classifier (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_req,
    output logic                   in_ack,
    input  mlp_pkg::feature_vec_t  in_sample,
    output logic                   out_req,
    input  logic                   out_ack,
    output mlp_pkg::class_result_t out_result
);
    import mlp_pkg::*;

    // Receiver to queue
    feature_vec_t rx_data;
    logic         rx_valid;
    logic         rx_ready;

    // Queue to layer 1
    feature_vec_t q_data;
    logic         q_valid;
    logic         q_ready;

    // Layer 1 to layer 2
    hidden_vec_t  hidden;
    logic         hidden_valid;
    logic         hidden_ready;

    // Layer 2 to sender
    logit_vec_t   logits;
    logic         logit_valid;
    logic         logit_ready;

    sample_receiver u_receiver (
        .clk          (clk),
        .reset        (reset),
        .in_req       (in_req),
        .in_ack       (in_ack),
        .in_sample    (in_sample),
        .sample_valid (rx_valid),
        .sample_ready (rx_ready),
        .sample_data  (rx_data)
    );

    sample_queue u_queue (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (rx_valid),
        .wr_ready (rx_ready),
        .wr_data  (rx_data),
        .rd_valid (q_valid),
        .rd_ready (q_ready),
        .rd_data  (q_data)
    );

    dense_layer #(
        .IN_SIZE  (`MLP_N_IN),
        .OUT_SIZE (`MLP_N_HID),
        .USE_RELU (1'b1),
        .WEIGHTS  (layer1_weights),
        .BIAS     (layer1_bias)
    ) u_layer1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (q_valid),
        .in_ready  (q_ready),
        .in_data   (q_data),
        .out_valid (hidden_valid),
        .out_ready (hidden_ready),
        .out_data  (hidden)
    );

    // Output layer gives raw logits
    dense_layer #(
        .IN_SIZE  (`MLP_N_HID),
        .OUT_SIZE (`MLP_N_OUT),
        .USE_RELU (1'b0),
        .WEIGHTS  (layer2_weights),
        .BIAS     (layer2_bias)
    ) u_layer2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (hidden_valid),
        .in_ready  (hidden_ready),
        .in_data   (hidden),
        .out_valid (logit_valid),
        .out_ready (logit_ready),
        .out_data  (logits)
    );

    argmax_sender u_sender (
        .clk         (clk),
        .reset       (reset),
        .logit_valid (logit_valid),
        .logit_ready (logit_ready),
        .logits      (logits),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_result  (out_result)
    );

endmodule

/* verif/mlp_classifier_sva.sv */
`timescale 1ns/10ps

module mlp_classifier_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   in_req,
    input logic                   in_ack,
    input mlp_pkg::feature_vec_t  in_sample,
    input logic                   out_req,
    input logic                   out_ack,
    input mlp_pkg::class_result_t out_result
);

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> in_req)
        else $error("in_ack rose while in_req was low");

    sample_stable: assert property (@(posedge clk) disable iff (reset)
        (in_req && $past(in_req)) |-> $stable(in_sample))
        else $error("in_sample changed during a request");

    result_stable: assert property (@(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> $stable(out_result))
        else $error("out_result changed during a request");

    // New request waits for the previous ack to fall
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(out_req) |-> !out_ack)
        else $error("out_req rose while out_ack was high");

    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> (!in_ack && !out_req))
        else $error("in_ack or out_req high right after reset");

endmodule

bind mlp_classifier mlp_classifier_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .in_sample  (in_sample),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_result (out_result)
);

/* verif/mlp_classifier_tb.sv */
`timescale 1ns/10ps
`include "mlp_defines.svh"

module mlp_classifier_tb;
    import mlp_pkg::*;

    localparam int N_DIRECTED  = 12;
    localparam int N_RANDOM    = 40;
    localparam int N_TOTAL     = N_DIRECTED + N_RANDOM;
    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 20000;
    localparam int STALL_MIN   = 100;

    localparam longint FIX_MAX = (longint'(1) << (`MLP_WIDTH - 1)) - 1;
    localparam longint FIX_MIN = -(longint'(1) << (`MLP_WIDTH - 1));

    typedef struct packed {
        fixed_t     x0;
        fixed_t     x1;
        fixed_t     x2;
        fixed_t     x3;
        logic [9:0] ack_delay;
    } stim_t;

    typedef struct packed {
        class_result_t result;
        logic [9:0]    ack_delay;
    } expect_t;

    // Columns are x0, x1, x2, x3 and the out_ack delay in cycles
    localparam stim_t STIM_TABLE [N_DIRECTED] = '{
        '{   256,    128,    -64,     32,   0},
        '{   512,    256,    384,    128,   2},
        '{  -256,   -512,   -128,   -384,   0},
        // Biases only so logits 0 and 1 tie
        '{     0,      0,      0,      0,   1},
        '{ 32767,  32767,  32767,  32767,   0},
        '{-32768, -32768, -32768, -32768,   0},
        // Sign patterns that push hidden neurons past the fixed_t maximum
        '{ 32767, -32768,  32767,  32767,   3},
        '{-32768, -32768,  32767,  32767,   0},
        // Long out_ack stalls fill the whole pipeline
        '{   768,   -384,    640,   -128, 250},
        '{  -640,    896,    128,    512, 250},
        '{   384,    384,   -768,   1024, 250},
        '{   100,   -200,    300,   -400,   0}
    };

    logic          clk;
    logic          reset;
    logic          in_req;
    logic          in_ack;
    feature_vec_t  in_sample;
    logic          out_req;
    logic          out_ack;
    class_result_t out_result;

    expect_t     exp_q [$];
    int          error_count;
    int          check_count;
    int          timeout_count;
    int          result_count;
    int          max_ack_wait;
    logic [31:0] rng_state;

    mlp_classifier dut (
        .clk        (clk),
        .reset      (reset),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_sample  (in_sample),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Floor shift, bias, saturation and optional ReLU
    function automatic fixed_t neuron_value(input longint acc, input fixed_t bias, input bit relu);
        longint v;
        v = (acc >>> `MLP_NFRAC) + longint'(bias);
        if (v > FIX_MAX) begin
            v = FIX_MAX;
        end else if (v < FIX_MIN) begin
            v = FIX_MIN;
        end
        if (relu && (v < 0)) begin
            v = 0;
        end
        return fixed_t'(v);
    endfunction

    function automatic class_result_t classify(input feature_vec_t s);
        fixed_t        x [`MLP_N_IN];
        fixed_t        h [`MLP_N_HID];
        fixed_t        z [`MLP_N_OUT];
        longint        acc;
        class_result_t r;
        int            n;
        int            i;
        x[0] = s.x0;
        x[1] = s.x1;
        x[2] = s.x2;
        x[3] = s.x3;
        for (n = 0; n < `MLP_N_HID; n++) begin
            acc = 0;
            for (i = 0; i < `MLP_N_IN; i++) begin
                acc += longint'(x[i]) * longint'(layer1_weights[n][i]);
            end
            h[n] = neuron_value(acc, layer1_bias[n], 1'b1);
        end
        for (n = 0; n < `MLP_N_OUT; n++) begin
            acc = 0;
            for (i = 0; i < `MLP_N_HID; i++) begin
                acc += longint'(h[i]) * longint'(layer2_weights[n][i]);
            end
            z[n] = neuron_value(acc, layer2_bias[n], 1'b0);
        end
        // Lowest index wins a tie
        r.class_idx = 2'd0;
        r.logit     = z[0];
        for (n = 1; n < `MLP_N_OUT; n++) begin
            if (z[n] > r.logit) begin
                r.class_idx = 2'(n);
                r.logit     = z[n];
            end
        end
        return r;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
                 timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        timeout_count++;
    endtask

    task automatic next_random_stim(output stim_t st);
        rng_state    = xorshift32(rng_state);
        st.x0        = fixed_t'($signed(rng_state[15:0]) >>> 3);
        st.x1        = fixed_t'($signed(rng_state[31:16]) >>> 3);
        rng_state    = xorshift32(rng_state);
        st.x2        = fixed_t'($signed(rng_state[15:0]) >>> 3);
        st.x3        = fixed_t'($signed(rng_state[31:16]) >>> 3);
        st.ack_delay = '0;
    endtask

    task automatic send_sample(input stim_t st);
        feature_vec_t s;
        expect_t      e;
        int           cycles;
        s.x0        = st.x0;
        s.x1        = st.x1;
        s.x2        = st.x2;
        s.x3        = st.x3;
        e.result    = classify(s);
        e.ack_delay = st.ack_delay;
        exp_q.push_back(e);
        @(posedge clk);
        in_sample <= s;
        in_req    <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!in_ack && (cycles < WAIT_LIMIT));
        if (!in_ack) begin
            report_timeout("in_ack did not rise for a pending request");
        end else begin
            if (cycles > max_ack_wait) begin
                max_ack_wait = cycles;
            end
            @(posedge clk);
            in_req <= 1'b0;
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (in_ack && (cycles < WAIT_LIMIT));
            if (in_ack) begin
                report_timeout("in_ack stayed high after in_req fell");
            end
        end
    endtask

    initial begin
        stim_t st;
        int    cycles;
        clk           = 1'b0;
        reset         = 1'b1;
        in_req        = 1'b0;
        in_sample     = '0;
        out_ack       = 1'b0;
        error_count   = 0;
        check_count   = 0;
        timeout_count = 0;
        result_count  = 0;
        max_ack_wait  = 0;
        rng_state     = 32'd25;
        repeat (5) begin
            @(negedge clk);
            check_count++;
            assert (!in_ack && !out_req) else begin
                $display("error %0t: in_ack or out_req high during reset", $time);
                error_count++;
            end
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_count++;
        assert (!in_ack && !out_req) else begin
            $display("error %0t: in_ack or out_req high after reset", $time);
            error_count++;
        end
        for (int k = 0; (k < N_DIRECTED) && (timeout_count == 0); k++) begin
            send_sample(STIM_TABLE[k]);
        end
        for (int k = 0; (k < N_RANDOM) && (timeout_count == 0); k++) begin
            next_random_stim(st);
            send_sample(st);
        end
        cycles = 0;
        while ((result_count < N_TOTAL) && (timeout_count == 0) && (cycles < DRAIN_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if ((timeout_count == 0) && (result_count < N_TOTAL)) begin
            report_timeout("not every submitted sample produced a result");
        end
        if (timeout_count == 0) begin
            check_count++;
            assert (max_ack_wait > STALL_MIN) else begin
                $display("error %0t: in_ack never stalled while out_ack was held off", $time);
                error_count++;
            end
        end
        finish_run();
    end

    // One four-phase output cycle per expected result
    initial begin
        expect_t e;
        int      cycles;
        while ((result_count < N_TOTAL) && (timeout_count == 0)) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!out_req && (cycles < WAIT_LIMIT));
            if (!out_req) begin
                report_timeout("out_req did not rise for an outstanding sample");
            end else begin
                e = '0;
                check_count++;
                assert (exp_q.size() > 0) else begin
                    $display("error %0t: result %0d arrived with no sample outstanding", $time,
                             result_count);
                    error_count++;
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    check_count += 2;
                    assert (out_result.class_idx == e.result.class_idx) else begin
                        $display("error %0t: result %0d class %0d, expected %0d", $time,
                                 result_count, out_result.class_idx, e.result.class_idx);
                        error_count++;
                    end
                    assert (out_result.logit == e.result.logit) else begin
                        $display("error %0t: result %0d logit %0d, expected %0d", $time,
                                 result_count, out_result.logit, e.result.logit);
                        error_count++;
                    end
                end
                repeat (e.ack_delay) @(posedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                cycles = 0;
                do begin
                    @(negedge clk);
                    cycles++;
                end while (out_req && (cycles < WAIT_LIMIT));
                if (out_req) begin
                    report_timeout("out_req stayed high after out_ack rose");
                end else begin
                    @(posedge clk);
                    out_ack <= 1'b0;
                    result_count++;
                end
            end
        end
    end

endmodule

/* build.f */
+incdir+rtl
rtl/mlp_pkg.sv
rtl/sample_receiver.sv
rtl/sample_queue.sv
rtl/dense_layer.sv
rtl/argmax_sender.sv
rtl/mlp_classifier.sv
verif/mlp_classifier_sva.sv
verif/mlp_classifier_tb.sv

/* Bender.yml */
package:
  name: mlp_classifier

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mlp_pkg.sv
      - rtl/sample_receiver.sv
      - rtl/sample_queue.sv
      - rtl/dense_layer.sv
      - rtl/argmax_sender.sv
      - rtl/mlp_classifier.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/mlp_classifier_sva.sv
      - verif/mlp_classifier_tb.sv
